// File: axis_in_pkg.sv
`default_nettype none

package axis_in_pkg;

   localparam int unsigned WORD_W = 32;
   localparam int unsigned LANES = 4;
   localparam int unsigned LEVEL_W = 16;

   typedef logic [WORD_W-1:0]  word_t;
   typedef logic [LANES-1:0]   lane_mask_t;
   typedef logic [2:0]         csr_addr_t;
   typedef logic [LEVEL_W-1:0] level_t;

   // One 40-bit FIFO entry
   typedef struct packed {
      word_t      data;
      lane_mask_t strb;
      lane_mask_t last;
   } fifo_word_t;

   typedef struct packed {
      logic soft_reset;
      logic enable;
   } csr_ctrl_t;

   typedef enum logic {
      WRITE   = 1'b0,
      PADDING = 1'b1
   } pack_state_e;

   // CSR word addresses
   localparam csr_addr_t ADDR_SOFT_RESET = 3'd0;
   localparam csr_addr_t ADDR_ENABLE     = 3'd1;
   localparam csr_addr_t ADDR_DATA       = 3'd2;
   localparam csr_addr_t ADDR_STRB       = 3'd3;
   localparam csr_addr_t ADDR_LAST       = 3'd4;
   localparam csr_addr_t ADDR_EMPTY      = 3'd5;
   localparam csr_addr_t ADDR_LEVEL      = 3'd6;
   localparam csr_addr_t ADDR_THRESHOLD  = 3'd7;

endpackage

`default_nettype wire

// File: axis_in_csr.sv
`timescale 1ns/10ps
`default_nettype none

module axis_in_csr (
   input  wire logic                   clk_i,
   input  wire logic                   rst_n_i,
   input  wire logic                   csr_valid_i,
   input  wire axis_in_pkg::csr_addr_t csr_addr_i,
   input  wire axis_in_pkg::word_t     csr_wdata_i,
   input  wire logic                   csr_we_i,
   output logic                        csr_rvalid_o,
   output axis_in_pkg::word_t          csr_rdata_o,
   output axis_in_pkg::csr_ctrl_t      ctrl_o,
   input  wire axis_in_pkg::fifo_word_t head_i,
   input  wire logic                   empty_i,
   input  wire axis_in_pkg::level_t    level_i,
   output logic                        pop_o,
   output logic                        threshold_o
);

   logic                    wr_en;
   logic                    rd_en;
   axis_in_pkg::level_t     thresh_q;
   axis_in_pkg::lane_mask_t strb_q;
   logic                    last_q;
   axis_in_pkg::word_t      rdata_nxt;

   assign wr_en = csr_valid_i & csr_we_i;
   assign rd_en = csr_valid_i & ~csr_we_i;

   // Pop only when there is something to take
   assign pop_o = rd_en & (csr_addr_i == axis_in_pkg::ADDR_DATA) & ~empty_i;

   assign threshold_o = (level_i >= thresh_q);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_o   <= '0;
         thresh_q <= '1;
      end else if (wr_en) begin
         case (csr_addr_i)
            axis_in_pkg::ADDR_SOFT_RESET: ctrl_o.soft_reset <= csr_wdata_i[0];
            axis_in_pkg::ADDR_ENABLE:     ctrl_o.enable <= csr_wdata_i[0];
            axis_in_pkg::ADDR_THRESHOLD:  thresh_q <= csr_wdata_i[$bits(thresh_q)-1:0];
            default: ;
         endcase
      end
   end

   // Lane flags of the word taken by the last DATA read
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         strb_q <= '0;
         last_q <= 1'b0;
      end else if (pop_o) begin
         strb_q <= head_i.strb;
         last_q <= |head_i.last;
      end
   end

   always_comb begin
      rdata_nxt = '0;
      case (csr_addr_i)
         axis_in_pkg::ADDR_DATA:      rdata_nxt = empty_i ? '0 : head_i.data;
         axis_in_pkg::ADDR_STRB:      rdata_nxt = axis_in_pkg::word_t'(strb_q);
         axis_in_pkg::ADDR_LAST:      rdata_nxt = axis_in_pkg::word_t'(last_q);
         axis_in_pkg::ADDR_EMPTY:     rdata_nxt = axis_in_pkg::word_t'(empty_i);
         axis_in_pkg::ADDR_LEVEL:     rdata_nxt = axis_in_pkg::word_t'(level_i);
         axis_in_pkg::ADDR_THRESHOLD: rdata_nxt = axis_in_pkg::word_t'(thresh_q);
         default:                     rdata_nxt = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         csr_rvalid_o <= 1'b0;
      end else begin
         csr_rvalid_o <= rd_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         csr_rdata_o <= rdata_nxt;
      end
   end

endmodule

`default_nettype wire

// File: axis_in_packer.sv
`timescale 1ns/10ps
`default_nettype none

module axis_in_packer #(
   parameter int unsigned TDATA_W = 8
) (
   input  wire logic                   axis_clk_i,
   input  wire logic                   rst_n_i,
   input  wire axis_in_pkg::csr_ctrl_t ctrl_i,
   input  wire logic [TDATA_W-1:0]     axis_tdata_i,
   input  wire logic                   axis_tvalid_i,
   input  wire logic                   axis_tlast_i,
   output logic                        axis_tready_o,
   input  wire logic                   full_i,
   output logic                        wr_o,
   output axis_in_pkg::fifo_word_t     wr_word_o,
   output logic                        sw_rst_o
);

   localparam int unsigned N = 32 / TDATA_W;
   localparam int unsigned CNT_W = (N > 1) ? $clog2(N) : 1;
   localparam logic [CNT_W-1:0] TOP_LANE = CNT_W'(N - 1);

   axis_in_pkg::csr_ctrl_t   ctrl_meta;
   axis_in_pkg::csr_ctrl_t   ctrl_sync;
   axis_in_pkg::pack_state_e state_q;
   axis_in_pkg::pack_state_e state_nxt;
   logic [CNT_W-1:0]         lane_q;
   logic [CNT_W-1:0]         lane_nxt;
   axis_in_pkg::word_t       data_q;
   axis_in_pkg::word_t       data_nxt;
   logic [N-1:0]             strb_q;
   logic [N-1:0]             strb_nxt;
   logic [N-1:0]             last_q;
   logic [N-1:0]             last_nxt;
   logic                     ready_int;
   logic                     accept;
   logic                     step;
   logic                     top_lane;

   // Two-flop synchronizer for the control bits
   always_ff @(posedge axis_clk_i) begin
      if (!rst_n_i) begin
         ctrl_meta <= '0;
         ctrl_sync <= '0;
      end else begin
         ctrl_meta <= ctrl_i;
         ctrl_sync <= ctrl_meta;
      end
   end

   assign sw_rst_o = ctrl_sync.soft_reset;

   assign ready_int     = ctrl_sync.enable & ~full_i;
   assign axis_tready_o = ready_int & (state_q == axis_in_pkg::WRITE);
   assign accept        = axis_tvalid_i & axis_tready_o;
   // Steps one lane per cycle for a real beat or a padding lane
   assign step          = accept | (ready_int & (state_q == axis_in_pkg::PADDING));
   assign top_lane      = (lane_q == TOP_LANE);

   always_comb begin
      data_nxt = data_q;
      strb_nxt = strb_q;
      last_nxt = last_q;
      data_nxt[lane_q*TDATA_W +: TDATA_W] = accept ? axis_tdata_i : '0;
      strb_nxt[lane_q] = accept;
      last_nxt[lane_q] = accept & axis_tlast_i;
   end

   always_comb begin
      state_nxt = state_q;
      lane_nxt  = lane_q;
      if (step) begin
         if (top_lane) begin
            lane_nxt  = '0;
            state_nxt = axis_in_pkg::WRITE;
         end else begin
            lane_nxt = lane_q + 1'b1;
            if (accept && axis_tlast_i) begin
               state_nxt = axis_in_pkg::PADDING;
            end
         end
      end
   end

   always_ff @(posedge axis_clk_i) begin
      if (!rst_n_i || sw_rst_o) begin
         state_q <= axis_in_pkg::WRITE;
         lane_q  <= '0;
      end else begin
         state_q <= state_nxt;
         lane_q  <= lane_nxt;
      end
   end

   always_ff @(posedge axis_clk_i) begin
      if (step) begin
         data_q <= data_nxt;
         strb_q <= strb_nxt;
         last_q <= last_nxt;
      end
   end

   // Word leaves on the edge that fills the top lane
   assign wr_o      = step & top_lane;
   assign wr_word_o = '{data: data_nxt,
                        strb: axis_in_pkg::lane_mask_t'(strb_nxt),
                        last: axis_in_pkg::lane_mask_t'(last_nxt)};

endmodule

`default_nettype wire

// File: axis_in_async_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module axis_in_async_fifo #(
   parameter int unsigned FIFO_DEPTH_LOG2 = 4
) (
   input  wire logic                    w_clk_i,
   input  wire logic                    w_rst_i,
   input  wire logic                    w_en_i,
   input  wire axis_in_pkg::fifo_word_t w_data_i,
   output logic                         w_full_o,
   input  wire logic                    r_clk_i,
   input  wire logic                    r_rst_i,
   input  wire logic                    r_en_i,
   output axis_in_pkg::fifo_word_t      r_data_o,
   output logic                         r_empty_o,
   output axis_in_pkg::level_t          r_level_o
);

   localparam int unsigned AW = FIFO_DEPTH_LOG2;
   localparam int unsigned PW = AW + 1;
   localparam int unsigned DEPTH = 1 << AW;

   typedef logic [PW-1:0] ptr_t;

   function automatic ptr_t bin2gray(input ptr_t b);
      return b ^ (b >> 1);
   endfunction

   function automatic ptr_t gray2bin(input ptr_t g);
      ptr_t b;
      b[PW-1] = g[PW-1];
      for (int i = PW - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   axis_in_pkg::fifo_word_t mem [DEPTH];

   ptr_t w_bin;
   ptr_t w_gray;
   ptr_t rg_meta;
   ptr_t rg_sync;
   ptr_t r_bin_w;
   logic w_push;

   ptr_t r_bin;
   ptr_t r_gray;
   ptr_t wg_meta;
   ptr_t wg_sync;
   ptr_t w_bin_r;
   ptr_t r_fill;
   logic r_pop;

   // Write side
   assign r_bin_w  = gray2bin(rg_sync);
   assign w_full_o = (w_bin[AW] != r_bin_w[AW]) && (w_bin[AW-1:0] == r_bin_w[AW-1:0]);
   assign w_push   = w_en_i & ~w_full_o;

   always_ff @(posedge w_clk_i) begin
      if (w_rst_i) begin
         w_bin  <= '0;
         w_gray <= '0;
      end else if (w_push) begin
         w_bin  <= w_bin + 1'b1;
         w_gray <= bin2gray(w_bin + 1'b1);
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_rst_i) begin
         rg_meta <= '0;
         rg_sync <= '0;
      end else begin
         rg_meta <= r_gray;
         rg_sync <= rg_meta;
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_push) begin
         mem[w_bin[AW-1:0]] <= w_data_i;
      end
   end

   // Read side
   assign w_bin_r   = gray2bin(wg_sync);
   assign r_empty_o = (wg_sync == r_gray);
   assign r_pop     = r_en_i & ~r_empty_o;
   assign r_fill    = w_bin_r - r_bin;
   assign r_level_o = axis_in_pkg::level_t'(r_fill);

   // Show-ahead head of queue
   assign r_data_o = mem[r_bin[AW-1:0]];

   always_ff @(posedge r_clk_i) begin
      if (r_rst_i) begin
         r_bin  <= '0;
         r_gray <= '0;
      end else if (r_pop) begin
         r_bin  <= r_bin + 1'b1;
         r_gray <= bin2gray(r_bin + 1'b1);
      end
   end

   always_ff @(posedge r_clk_i) begin
      if (r_rst_i) begin
         wg_meta <= '0;
         wg_sync <= '0;
      end else begin
         wg_meta <= w_gray;
         wg_sync <= wg_meta;
      end
   end

endmodule

`default_nettype wire

// File: axis_in_dma_out.sv
`timescale 1ns/10ps
`default_nettype none

module axis_in_dma_out (
   input  wire logic                    clk_i,
   input  wire logic                    rst_n_i,
   input  wire axis_in_pkg::csr_ctrl_t  ctrl_i,
   input  wire axis_in_pkg::fifo_word_t head_i,
   input  wire logic                    empty_i,
   output logic                         pop_o,
   output axis_in_pkg::word_t           tdata_o,
   output logic                         tvalid_o,
   input  wire logic                    tready_i
);

   // Refill only while the sink is ready, so with tready_i low the
   // FIFO is left to the CSR reader
   assign pop_o = tready_i & ctrl_i.enable & ~empty_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || ctrl_i.soft_reset) begin
         tvalid_o <= 1'b0;
      end else if (tready_i) begin
         tvalid_o <= ctrl_i.enable & ~empty_i;
      end
   end

   // Held under back-pressure
   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         tdata_o <= head_i.data;
      end
   end

endmodule

`default_nettype wire

// File: axis_in.sv
`timescale 1ns/10ps
`default_nettype none

module axis_in #(
   parameter int unsigned TDATA_W = 8,
   parameter int unsigned FIFO_DEPTH_LOG2 = 4
) (
   input  wire logic                   clk_i,
   input  wire logic                   axis_clk_i,
   input  wire logic                   rst_n_i,
   input  wire logic [TDATA_W-1:0]     axis_tdata_i,
   input  wire logic                   axis_tvalid_i,
   input  wire logic                   axis_tlast_i,
   output logic                        axis_tready_o,
   input  wire logic                   csr_valid_i,
   input  wire axis_in_pkg::csr_addr_t csr_addr_i,
   input  wire axis_in_pkg::word_t     csr_wdata_i,
   input  wire logic                   csr_we_i,
   output logic                        csr_rvalid_o,
   output axis_in_pkg::word_t          csr_rdata_o,
   output axis_in_pkg::word_t          tdata_o,
   output logic                        tvalid_o,
   input  wire logic                   tready_i,
   output logic                        threshold_o
);

   axis_in_pkg::csr_ctrl_t  ctrl;
   axis_in_pkg::fifo_word_t head;
   axis_in_pkg::fifo_word_t wr_word;
   axis_in_pkg::level_t     level;
   logic                    empty;
   logic                    full;
   logic                    wr;
   logic                    csr_pop;
   logic                    dma_pop;
   logic                    axis_sw_rst;
   logic                    fifo_w_rst;
   logic                    fifo_r_rst;

   // Each FIFO side sees rst_n_i and the soft reset in its own domain
   assign fifo_w_rst = ~rst_n_i | axis_sw_rst;
   assign fifo_r_rst = ~rst_n_i | ctrl.soft_reset;

   axis_in_csr u_csr (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .csr_valid_i (csr_valid_i),
      .csr_addr_i  (csr_addr_i),
      .csr_wdata_i (csr_wdata_i),
      .csr_we_i    (csr_we_i),
      .csr_rvalid_o(csr_rvalid_o),
      .csr_rdata_o (csr_rdata_o),
      .ctrl_o      (ctrl),
      .head_i      (head),
      .empty_i     (empty),
      .level_i     (level),
      .pop_o       (csr_pop),
      .threshold_o (threshold_o)
   );

   axis_in_packer #(
      .TDATA_W(TDATA_W)
   ) u_packer (
      .axis_clk_i   (axis_clk_i),
      .rst_n_i      (rst_n_i),
      .ctrl_i       (ctrl),
      .axis_tdata_i (axis_tdata_i),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tlast_i (axis_tlast_i),
      .axis_tready_o(axis_tready_o),
      .full_i       (full),
      .wr_o         (wr),
      .wr_word_o    (wr_word),
      .sw_rst_o     (axis_sw_rst)
   );

   axis_in_async_fifo #(
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) u_fifo (
      .w_clk_i  (axis_clk_i),
      .w_rst_i  (fifo_w_rst),
      .w_en_i   (wr),
      .w_data_i (wr_word),
      .w_full_o (full),
      .r_clk_i  (clk_i),
      .r_rst_i  (fifo_r_rst),
      .r_en_i   (csr_pop | dma_pop),
      .r_data_o (head),
      .r_empty_o(empty),
      .r_level_o(level)
   );

   axis_in_dma_out u_dma_out (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .ctrl_i  (ctrl),
      .head_i  (head),
      .empty_i (empty),
      .pop_o   (dma_pop),
      .tdata_o (tdata_o),
      .tvalid_o(tvalid_o),
      .tready_i(tready_i)
   );

endmodule

`default_nettype wire

// File: axis_in_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module axis_in_asserts (
   input wire logic               clk_i,
   input wire logic               rst_n_i,
   input wire logic               csr_valid_i,
   input wire logic               csr_we_i,
   input wire logic               csr_rvalid_o,
   input wire axis_in_pkg::word_t tdata_o,
   input wire logic               tvalid_o,
   input wire logic               tready_i
);

   int unsigned fail_cnt = 0;

   // Output word frozen under back-pressure
   dma_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (tvalid_o && !tready_i) |=> (tvalid_o && $stable(tdata_o)))
   else begin
      $error("DMA output changed while tready_i was low");
      fail_cnt++;
   end

   csr_read_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      csr_rvalid_o == $past(csr_valid_i && !csr_we_i))
   else begin
      $error("csr_rvalid_o did not follow the read strobe by one cycle");
      fail_cnt++;
   end

   reset_quiet: assert property (@(posedge clk_i)
      !rst_n_i |=> (!tvalid_o && !csr_rvalid_o))
   else begin
      $error("valid outputs high during reset");
      fail_cnt++;
   end

endmodule

bind axis_in axis_in_asserts u_asserts (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .csr_valid_i (csr_valid_i),
   .csr_we_i    (csr_we_i),
   .csr_rvalid_o(csr_rvalid_o),
   .tdata_o     (tdata_o),
   .tvalid_o    (tvalid_o),
   .tready_i    (tready_i)
);

`default_nettype wire

// File: tb_axis_in.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axis_in;

   localparam int TDATA_W = 8;
   localparam int FIFO_DEPTH_LOG2 = 4;
   localparam int LANES = 32 / TDATA_W;
   localparam int NUM_PACKETS = 35;
   localparam int WATCHDOG_CYCLES = 200 * NUM_PACKETS + 1000;

   typedef logic [TDATA_W-1:0] beat_t;

   logic                    clk_i;
   logic                    axis_clk_i;
   logic                    rst_n_i;
   logic [TDATA_W-1:0]      axis_tdata_i;
   logic                    axis_tvalid_i;
   logic                    axis_tlast_i;
   logic                    axis_tready_o;
   logic                    csr_valid_i;
   axis_in_pkg::csr_addr_t  csr_addr_i;
   axis_in_pkg::word_t      csr_wdata_i;
   logic                    csr_we_i;
   logic                    csr_rvalid_o;
   axis_in_pkg::word_t      csr_rdata_o;
   axis_in_pkg::word_t      tdata_o;
   logic                    tvalid_o;
   logic                    tready_i;
   logic                    threshold_o;

   axis_in_pkg::fifo_word_t exp_q[$];
   axis_in_pkg::fifo_word_t last_taken;
   axis_in_pkg::csr_addr_t  rd_addr;
   axis_in_pkg::word_t      rd;
   logic                    rand_ready;
   int                      seed;
   int                      len;

   axis_in #(
      .TDATA_W        (TDATA_W),
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) u_axis_in (
      .clk_i        (clk_i),
      .axis_clk_i   (axis_clk_i),
      .rst_n_i      (rst_n_i),
      .axis_tdata_i (axis_tdata_i),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tlast_i (axis_tlast_i),
      .axis_tready_o(axis_tready_o),
      .csr_valid_i  (csr_valid_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_we_i     (csr_we_i),
      .csr_rvalid_o (csr_rvalid_o),
      .csr_rdata_o  (csr_rdata_o),
      .tdata_o      (tdata_o),
      .tvalid_o     (tvalid_o),
      .tready_i     (tready_i),
      .threshold_o  (threshold_o)
   );

   // Rising edges of the two clocks never coincide
   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   initial begin
      axis_clk_i = 1'b0;
      forever #6 axis_clk_i = ~axis_clk_i;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "run aborted");
   endtask

   task automatic check(input axis_in_pkg::word_t actual, input axis_in_pkg::word_t expected,
                        input string what);
      if (actual !== expected) begin
         $display("error at %0t ns: %s, got 0x%08h, expected 0x%08h",
                  $time, what, actual, expected);
         $display("*** TEST FAILED ***");
         $fatal(1, "value mismatch");
      end
   endtask

   // Lanes fill from lane 0 and a short final word gets zero padding
   function automatic void pack_expected(input beat_t beats[$]);
      axis_in_pkg::fifo_word_t w;
      int lane;
      int i;
      w = '0;
      lane = 0;
      for (i = 0; i < beats.size(); i++) begin
         w.data[lane*TDATA_W +: TDATA_W] = beats[i];
         w.strb[lane] = 1'b1;
         w.last[lane] = (i == beats.size() - 1);
         lane++;
         if (lane == LANES || i == beats.size() - 1) begin
            exp_q.push_back(w);
            w = '0;
            lane = 0;
         end
      end
   endfunction

   task automatic take_expected(input axis_in_pkg::word_t got, input string what);
      if (exp_q.size() == 0) begin
         abort_run({what, " delivered a word that was never sent"});
      end else begin
         last_taken = exp_q.pop_front();
         check(got, last_taken.data, what);
      end
   endtask

   // Compare process samples outputs between clk_i edges
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         if (tvalid_o && tready_i) begin
            take_expected(tdata_o, "DMA output");
         end
         if (csr_rvalid_o && rd_addr == axis_in_pkg::ADDR_DATA) begin
            take_expected(csr_rdata_o, "CSR DATA read");
         end
      end
   end

   always @(posedge clk_i) begin
      if (rand_ready) begin
         tready_i <= 1'($random(seed));
      end
   end

   task automatic csr_write(input axis_in_pkg::csr_addr_t addr, input axis_in_pkg::word_t data);
      @(posedge clk_i);
      csr_valid_i <= 1'b1;
      csr_we_i    <= 1'b1;
      csr_addr_i  <= addr;
      csr_wdata_i <= data;
      @(posedge clk_i);
      csr_valid_i <= 1'b0;
      csr_we_i    <= 1'b0;
   endtask

   task automatic csr_read(input axis_in_pkg::csr_addr_t addr, output axis_in_pkg::word_t data);
      @(posedge clk_i);
      csr_valid_i <= 1'b1;
      csr_we_i    <= 1'b0;
      csr_addr_i  <= addr;
      rd_addr     <= addr;
      @(posedge clk_i);
      csr_valid_i <= 1'b0;
      @(negedge clk_i);
      while (!csr_rvalid_o) begin
         @(negedge clk_i);
      end
      data = csr_rdata_o;
   endtask

   task automatic send_packet(input int n);
      beat_t beats[$];
      int i;
      @(posedge axis_clk_i);
      for (i = 0; i < n; i++) begin
         beats.push_back(beat_t'($random(seed)));
      end
      pack_expected(beats);
      for (i = 0; i < n; i++) begin
         axis_tdata_i  <= beats[i];
         axis_tvalid_i <= 1'b1;
         axis_tlast_i  <= (i == n - 1);
         @(negedge axis_clk_i);
         while (!axis_tready_o) begin
            @(negedge axis_clk_i);
         end
         @(posedge axis_clk_i);
      end
      axis_tvalid_i <= 1'b0;
      axis_tlast_i  <= 1'b0;
   endtask

   // Pop one word through DATA, then check its lane flags
   task automatic read_word();
      axis_in_pkg::word_t value;
      csr_read(axis_in_pkg::ADDR_EMPTY, value);
      while (value[0]) begin
         csr_read(axis_in_pkg::ADDR_EMPTY, value);
      end
      csr_read(axis_in_pkg::ADDR_DATA, value);
      csr_read(axis_in_pkg::ADDR_STRB, value);
      check(value, axis_in_pkg::word_t'(last_taken.strb), "STRB after DATA read");
      csr_read(axis_in_pkg::ADDR_LAST, value);
      check(value, axis_in_pkg::word_t'(|last_taken.last), "LAST after DATA read");
   endtask

   task automatic send_and_read(input int n);
      send_packet(n);
      repeat ((n + LANES - 1) / LANES) read_word();
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("timeout: the run did not finish within %0d clk_i cycles", WATCHDOG_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "watchdog expired");
   end

   initial begin
      seed          = 84;
      rand_ready    = 1'b0;
      rd_addr       = '0;
      rst_n_i       = 1'b0;
      axis_tdata_i  = '0;
      axis_tvalid_i = 1'b0;
      axis_tlast_i  = 1'b0;
      csr_valid_i   = 1'b0;
      csr_addr_i    = '0;
      csr_wdata_i   = '0;
      csr_we_i      = 1'b0;
      tready_i      = 1'b0;
      repeat (4) @(posedge clk_i);
      rst_n_i <= 1'b1;

      @(negedge clk_i);
      check(tvalid_o, 0, "tvalid_o after reset");
      check(csr_rvalid_o, 0, "csr_rvalid_o after reset");
      check(axis_tready_o, 0, "axis_tready_o after reset");
      check(threshold_o, 0, "threshold_o after reset");
      csr_read(axis_in_pkg::ADDR_EMPTY, rd);
      check(rd, 1, "EMPTY after reset");
      csr_read(axis_in_pkg::ADDR_LEVEL, rd);
      check(rd, 0, "LEVEL after reset");

      // Whole words, then padded words
      csr_write(axis_in_pkg::ADDR_ENABLE, 1);
      send_and_read(4);
      send_and_read(8);
      send_and_read(4);
      send_and_read(12);
      send_and_read(1);
      send_and_read(2);
      send_and_read(3);
      send_and_read(5);
      send_and_read(6);

      // DMA path under random back-pressure
      rand_ready = 1'b1;
      repeat (8) begin
         len = ($random(seed) & 7) + 1;
         send_packet(len);
      end
      while (exp_q.size() != 0) begin
         @(negedge clk_i);
      end
      rand_ready = 1'b0;
      @(posedge clk_i);
      tready_i <= 1'b0;

      // Fill the FIFO until the input stalls
      repeat (16) send_packet(4);
      @(posedge axis_clk_i);
      axis_tdata_i  <= 8'h5a;
      axis_tvalid_i <= 1'b1;
      repeat (20) begin
         @(negedge axis_clk_i);
         check(axis_tready_o, 0, "axis_tready_o with the FIFO full");
      end
      @(posedge axis_clk_i);
      axis_tvalid_i <= 1'b0;
      csr_read(axis_in_pkg::ADDR_LEVEL, rd);
      check(rd, 16, "LEVEL with the FIFO full");
      csr_write(axis_in_pkg::ADDR_THRESHOLD, 10);
      @(negedge clk_i);
      check(threshold_o, 1, "threshold_o at level 16");
      repeat (7) read_word();
      @(negedge clk_i);
      check(threshold_o, 0, "threshold_o at level 9");

      // Soft reset drops the remaining words
      csr_write(axis_in_pkg::ADDR_SOFT_RESET, 1);
      repeat (4) @(posedge axis_clk_i);
      csr_write(axis_in_pkg::ADDR_SOFT_RESET, 0);
      repeat (4) @(posedge axis_clk_i);
      exp_q.delete();
      csr_read(axis_in_pkg::ADDR_EMPTY, rd);
      check(rd, 1, "EMPTY after soft reset");
      csr_read(axis_in_pkg::ADDR_LEVEL, rd);
      check(rd, 0, "LEVEL after soft reset");
      send_and_read(4);
      send_and_read(3);

      check(exp_q.size(), 0, "words left unread at the end");
      if (u_axis_in.u_asserts.fail_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
axis_in_pkg.sv
axis_in_csr.sv
axis_in_packer.sv
axis_in_async_fifo.sv
axis_in_dma_out.sv
axis_in.sv
axis_in_asserts.sv
tb_axis_in.sv

// File: Bender.yml
package:
  name: axis_in

sources:
  - files:
      - axis_in_pkg.sv
      - axis_in_csr.sv
      - axis_in_packer.sv
      - axis_in_async_fifo.sv
      - axis_in_dma_out.sv
      - axis_in.sv
  - target: test
    files:
      - axis_in_asserts.sv
      - tb_axis_in.sv
